//--- testbench/dcachePatterns.txt
// op(0 load, 1 store) addr wdata byteMask expRdata expFill expWb, all hex
// memory word at byte address A starts as (A >> 3) ^ 5a5a00000000 5a5a
// set 2, line 0x0040 first miss then hits
0 00000048 0000000000000000 00 5a5a000000005a53 1 0
0 00000048 0000000000000000 00 5a5a000000005a53 0 0
0 00000058 0000000000000000 00 5a5a000000005a51 0 0
1 00000050 1122334455667788 0f 0000000000000000 0 0
0 00000050 0000000000000000 00 5a5a000055667788 0 0
// fill way 1, then evict dirty way 0 and clean way 1
0 00000840 0000000000000000 00 5a5a000000005b52 1 0
0 00001040 0000000000000000 00 5a5a000000005852 1 1
0 00000050 0000000000000000 00 5a5a000055667788 1 0
0 00000840 0000000000000000 00 5a5a000000005b52 1 0
// set 0, store miss then partial store
1 00002000 deadbeefcafef00d ff 0000000000000000 1 0
0 00002000 0000000000000000 00 deadbeefcafef00d 0 0
1 00002018 aabbccddeeff0011 81 0000000000000000 0 0
0 00002018 0000000000000000 00 aa5a000000005e11 0 0
0 00002810 0000000000000000 00 5a5a000000005f58 1 0
0 00003000 0000000000000000 00 5a5a000000005c5a 1 1
0 00002018 0000000000000000 00 aa5a000000005e11 1 0
0 00002000 0000000000000000 00 deadbeefcafef00d 0 0
// back to set 2
0 00000058 0000000000000000 00 5a5a000000005a51 0 0
0 00000840 0000000000000000 00 5a5a000000005b52 0 0
1 00000858 0102030405060708 f0 0000000000000000 0 0
0 00000858 0000000000000000 00 0102030400005b51 0 0
0 00001858 0000000000000000 00 5a5a000000005951 1 0
0 00001040 0000000000000000 00 5a5a000000005852 1 1
0 00000858 0000000000000000 00 0102030400005b51 1 0
0 00000840 0000000000000000 00 5a5a000000005b52 0 0

//--- dcacheTop.f
verilog/dcachePkg.sv
verilog/dataStore.sv
verilog/tagStore.sv
verilog/lineTransfer.sv
verilog/dcacheCtrl.sv
verilog/dcacheTop.sv
testbench/clockGen.sv
testbench/memModel.sv
testbench/dcacheTb.sv

//--- testbench/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb
  import dcachePkg::*;
();

  localparam int    IndexWidth       = 6;
  localparam int    ClkPeriodNs      = 20;
  localparam int    ResetCycles      = 5;
  localparam int    DriveDelay       = 1;
  localparam int    HitLatency       = 2;
  localparam int    CyclesPerPattern = 200;
  localparam string PatternFile      = "testbench/dcachePatterns.txt";

  typedef struct packed {
    logic                 isWrite;
    logic [AddrWidth-1:0] addr;
    logic [XLEN-1:0]      wdata;
    logic [MaskWidth-1:0] byteMask;
    logic [XLEN-1:0]      expRdata;
    logic                 expFill;
    logic                 expWb;
  } pattern_t;

  logic                 clk;
  logic                 rst_n;
  logic                 cpuReqValid;
  cpuReq_t              cpuReq;
  logic                 cpuAck;
  logic [XLEN-1:0]      cpuRdata;
  logic                 memRdValid;
  memRdReq_t            memRdReq;
  logic                 memRdReady;
  logic [XLEN-1:0]      memRdData;
  logic                 memRdBeatValid;
  logic                 memRdLast;
  logic                 memWrValid;
  memWrReq_t            memWrReq;
  logic                 memWrReady;
  int                   rdCount;
  int                   wbCount;
  logic [AddrWidth-1:0] lastRdAddr;
  int                   memErrors;
  int                   errors;
  bit                   loadDone;
  pattern_t             patterns [$];

  clockGen #(.PeriodNs(ClkPeriodNs)) clockGen_inst (.clk_o(clk));

  dcacheTop #(
    .IndexWidth(IndexWidth)
  ) dcacheTop_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .cpuReqValid_i    (cpuReqValid),
    .cpuReq_i         (cpuReq),
    .cpuAck_o         (cpuAck),
    .cpuRdata_o       (cpuRdata),
    .memRdValid_o     (memRdValid),
    .memRdReq_o       (memRdReq),
    .memRdReady_i     (memRdReady),
    .memRdData_i      (memRdData),
    .memRdBeatValid_i (memRdBeatValid),
    .memRdLast_i      (memRdLast),
    .memWrValid_o     (memWrValid),
    .memWrReq_o       (memWrReq),
    .memWrReady_i     (memWrReady)
  );

  memModel memModel_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .memRdValid_i     (memRdValid),
    .memRdReq_i       (memRdReq),
    .memRdReady_o     (memRdReady),
    .memRdData_o      (memRdData),
    .memRdBeatValid_o (memRdBeatValid),
    .memRdLast_o      (memRdLast),
    .memWrValid_i     (memWrValid),
    .memWrReq_i       (memWrReq),
    .memWrReady_o     (memWrReady),
    .rdCount_o        (rdCount),
    .wbCount_o        (wbCount),
    .lastRdAddr_o     (lastRdAddr),
    .errCount_o       (memErrors)
  );

  task automatic loadPatterns;
    int          fd;
    int          n;
    string       line;
    logic [63:0] f [7];
    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      $display("could not open the pattern file %s", PatternFile);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != "/") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
          if (n == 7) begin
            patterns.push_back({f[0][0], f[1][31:0], f[2], f[3][7:0], f[4], f[5][0], f[6][0]});
          end else begin
            $display("malformed pattern line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic runAccess(input pattern_t p, input int idx);
    int cycles;
    int rdBefore;
    int wbBefore;
    rdBefore        = rdCount;
    wbBefore        = wbCount;
    cpuReq.isWrite  = p.isWrite;
    cpuReq.addr     = p.addr;
    cpuReq.wdata    = p.wdata;
    cpuReq.byteMask = p.byteMask;
    cpuReqValid     = 1'b1;
    cycles          = 0;
    while (!cpuAck && cycles < CyclesPerPattern) begin
      @(posedge clk);
      #DriveDelay;
      cycles++;
    end
    assert (cpuAck) else begin
      $display("pattern %0d never got an acknowledge", idx);
      errors++;
    end
    if (!p.isWrite) begin
      assert (cpuRdata == p.expRdata) else begin
        $display("Error: pattern %0d cpuRdata_o = %h, expected %h", idx, cpuRdata, p.expRdata);
        errors++;
      end
    end
    // second half of the four-phase handshake
    cpuReqValid = 1'b0;
    cycles      = 0;
    while (cpuAck && cycles < CyclesPerPattern) begin
      @(posedge clk);
      #DriveDelay;
      cycles++;
    end
    assert (!cpuAck) else begin
      $display("pattern %0d acknowledge stayed high after the request dropped", idx);
      errors++;
    end
    assert (rdCount - rdBefore == int'(p.expFill)) else begin
      $display("Error: pattern %0d burst reads = %h, expected %h", idx, rdCount - rdBefore,
               p.expFill);
      errors++;
    end
    assert (wbCount - wbBefore == int'(p.expWb)) else begin
      $display("Error: pattern %0d write-backs = %h, expected %h", idx, wbCount - wbBefore,
               p.expWb);
      errors++;
    end
    if (p.expFill) begin
      assert (lastRdAddr == (p.addr & ~32'(LineBytes - 1))) else begin
        $display("Error: pattern %0d memRdReq_o.addr = %h, expected %h", idx, lastRdAddr,
                 p.addr & ~32'(LineBytes - 1));
        errors++;
      end
    end
  endtask

  // hit timing measured from the first edge that samples the request
  task automatic checkHitLatency(input int idx);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!cpuAck && cycles <= HitLatency) begin
      @(posedge clk);
      #DriveDelay;
      cycles++;
    end
    assert (cycles == HitLatency) else begin
      $display("Error: pattern %0d cpuAck_o latency = %h, expected %h", idx, cycles, HitLatency);
      errors++;
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    cpuReqValid = 1'b0;
    cpuReq      = '0;
    errors      = 0;
    loadDone    = 1'b0;
    loadPatterns();
    loadDone = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    @(posedge clk);
    #DriveDelay;
    assert (!cpuAck && !memRdValid && !memWrValid) else begin
      $display("Error: after reset cpuAck_o = %h, memRdValid_o = %h, memWrValid_o = %h",
               cpuAck, memRdValid, memWrValid);
      errors++;
    end
    foreach (patterns[i]) begin
      if (!patterns[i].expFill) begin
        fork
          checkHitLatency(i);
        join_none
      end
      runAccess(patterns[i], i);
      wait fork;
    end
    $display("errors: %0d testbench, %0d memory model, %0d patterns", errors, memErrors,
             patterns.size());
    if (errors == 0 && memErrors == 0 && patterns.size() > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog sized by the number of pattern lines
  initial begin
    wait (loadDone);
    repeat ((patterns.size() + 2) * CyclesPerPattern) @(posedge clk);
    $display("timeout, the run did not finish in time");
    $display("errors: %0d testbench, %0d memory model", errors, memErrors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel
  import dcachePkg::*;
#(
  parameter int DepthWords = 4096
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 memRdValid_i,
  input  memRdReq_t            memRdReq_i,
  output logic                 memRdReady_o,
  output logic [XLEN-1:0]      memRdData_o,
  output logic                 memRdBeatValid_o,
  output logic                 memRdLast_o,
  input  logic                 memWrValid_i,
  input  memWrReq_t            memWrReq_i,
  output logic                 memWrReady_o,
  output int                   rdCount_o,
  output int                   wbCount_o,
  output logic [AddrWidth-1:0] lastRdAddr_o,
  output int                   errCount_o
);

  localparam int          DriveDelay = 1;
  localparam logic [63:0] InitKey    = 64'h5a5a_0000_0000_5a5a;
  localparam logic [31:0] LfsrSeed   = 32'hd662_a062;

  logic [XLEN-1:0] mem [DepthWords];
  logic [31:0]     lfsrState;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // stall of 0 to 3 cycles with one LFSR step per bit
  task automatic pickDelay(output int cycles);
    cycles = 0;
    repeat (2) begin
      lfsrState = lfsrNext(lfsrState);
      cycles    = (cycles << 1) | int'(lfsrState[0]);
    end
  endtask

  function automatic bit lineInRange(input logic [AddrWidth-1:0] addr);
    return (addr[OffsetWidth-1:0] == '0) && (int'(addr >> 3) + BeatsPerLine <= DepthWords);
  endfunction

  task automatic serveWrite;
    memWrReq_t req;
    int        delay;
    int        base;
    req = memWrReq_i;
    pickDelay(delay);
    // request must hold still under back-pressure
    repeat (delay) begin
      @(posedge clk);
      #DriveDelay;
      assert (memWrValid_i && memWrReq_i == req) else begin
        $display("write request dropped or changed while waiting for ready");
        errCount_o++;
      end
    end
    assert (lineInRange(req.addr)) else begin
      $display("Error: memWrReq_o.addr = %h is unaligned or out of range", req.addr);
      errCount_o++;
    end
    memWrReady_o = 1'b1;
    if (lineInRange(req.addr)) begin
      base = int'(req.addr >> 3);
      for (int b = 0; b < BeatsPerLine; b++) begin
        mem[base + b] = req.data[b*XLEN +: XLEN];
      end
    end
    @(posedge clk);
    #DriveDelay;
    memWrReady_o = 1'b0;
    wbCount_o++;
  endtask

  task automatic serveRead;
    memRdReq_t req;
    int        delay;
    int        base;
    req = memRdReq_i;
    pickDelay(delay);
    repeat (delay) begin
      @(posedge clk);
      #DriveDelay;
      assert (memRdValid_i && memRdReq_i == req) else begin
        $display("read request dropped or changed while waiting for ready");
        errCount_o++;
      end
    end
    assert (lineInRange(req.addr)) else begin
      $display("Error: memRdReq_o.addr = %h is unaligned or out of range", req.addr);
      errCount_o++;
    end
    memRdReady_o = 1'b1;
    lastRdAddr_o = req.addr;
    @(posedge clk);
    #DriveDelay;
    memRdReady_o = 1'b0;
    rdCount_o++;
    base = int'(req.addr >> 3);
    // lowest word first, last flag on the final beat
    for (int b = 0; b < BeatsPerLine; b++) begin
      memRdData_o      = lineInRange(req.addr) ? mem[base + b] : '0;
      memRdBeatValid_o = 1'b1;
      memRdLast_o      = (b == BeatsPerLine - 1);
      @(posedge clk);
      #DriveDelay;
    end
    memRdData_o      = '0;
    memRdBeatValid_o = 1'b0;
    memRdLast_o      = 1'b0;
  endtask

  initial begin
    memRdReady_o     = 1'b0;
    memRdData_o      = '0;
    memRdBeatValid_o = 1'b0;
    memRdLast_o      = 1'b0;
    memWrReady_o     = 1'b0;
    rdCount_o        = 0;
    wbCount_o        = 0;
    lastRdAddr_o     = '0;
    errCount_o       = 0;
    lfsrState        = LfsrSeed;
    // every word starts as its own word address with a fixed key
    for (int i = 0; i < DepthWords; i++) begin
      mem[i] = XLEN'(i) ^ InitKey;
    end
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #DriveDelay;
      assert (!(memRdValid_i && memWrValid_i)) else begin
        $display("read and write requests were raised together");
        errCount_o++;
      end
      if (memWrValid_i) begin
        serveWrite();
      end else if (memRdValid_i) begin
        serveRead();
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int PeriodNs = 20
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // free-running, 50% duty cycle
  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- verilog/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop
  import dcachePkg::*;
#(
  parameter int IndexWidth = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // processor side, four-phase
  input  logic                 cpuReqValid_i,
  input  cpuReq_t              cpuReq_i,
  output logic                 cpuAck_o,
  output logic [XLEN-1:0]      cpuRdata_o,
  // memory read side
  output logic                 memRdValid_o,
  output memRdReq_t            memRdReq_o,
  input  logic                 memRdReady_i,
  input  logic [XLEN-1:0]      memRdData_i,
  input  logic                 memRdBeatValid_i,
  input  logic                 memRdLast_i,
  // memory write side
  output logic                 memWrValid_o,
  output memWrReq_t            memWrReq_o,
  input  logic                 memWrReady_i
);

  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  logic [IndexWidth-1:0] lookupIndex;
  logic [TagWidth-1:0]   lookupTag;
  logic                  hit;
  logic                  hitWay;
  logic                  victimWay;
  logic                  victimDirty;
  logic [TagWidth-1:0]   victimTag;
  line_t [1:0]           readLines;
  logic [1:0]            wayWrite;
  logic                  storeMerge;
  cpuReq_t               storeReq;
  logic                  tagCommit;
  logic                  setDirty;
  logic                  fillStart;
  logic                  wbStart;
  logic [AddrWidth-1:0]  wbAddr;
  logic [AddrWidth-1:0]  fillAddr;
  line_t                 wbLine;
  line_t                 fillLine;
  logic                  fillDone;
  logic                  wbDone;

  dcacheCtrl #(
    .IndexWidth(IndexWidth)
  ) dcacheCtrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpuReqValid_i (cpuReqValid_i),
    .cpuReq_i      (cpuReq_i),
    .cpuAck_o      (cpuAck_o),
    .cpuRdata_o    (cpuRdata_o),
    .lookupIndex_o (lookupIndex),
    .lookupTag_o   (lookupTag),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .readLines_i   (readLines),
    .wayWrite_o    (wayWrite),
    .storeMerge_o  (storeMerge),
    .storeReq_o    (storeReq),
    .tagCommit_o   (tagCommit),
    .setDirty_o    (setDirty),
    .fillStart_o   (fillStart),
    .wbStart_o     (wbStart),
    .wbAddr_o      (wbAddr),
    .wbLine_o      (wbLine),
    .fillAddr_o    (fillAddr),
    .fillDone_i    (fillDone),
    .wbDone_i      (wbDone)
  );

  tagStore #(
    .IndexWidth(IndexWidth)
  ) tagStore_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (lookupTag),
    .tagCommit_i   (tagCommit),
    .setDirty_i    (setDirty),
    .hitWay_i      (hitWay),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore #(
    .IndexWidth(IndexWidth)
  ) dataStore_inst (
    .clk          (clk),
    .wayWrite_i   (wayWrite),
    .storeMerge_i (storeMerge),
    .index_i      (lookupIndex),
    .storeReq_i   (storeReq),
    .fillLine_i   (fillLine),
    .readLines_o  (readLines)
  );

  lineTransfer lineTransfer_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .fillStart_i      (fillStart),
    .fillAddr_i       (fillAddr),
    .wbStart_i        (wbStart),
    .wbAddr_i         (wbAddr),
    .wbLine_i         (wbLine),
    .fillDone_o       (fillDone),
    .wbDone_o         (wbDone),
    .fillLine_o       (fillLine),
    .memRdValid_o     (memRdValid_o),
    .memRdReq_o       (memRdReq_o),
    .memRdReady_i     (memRdReady_i),
    .memRdData_i      (memRdData_i),
    .memRdBeatValid_i (memRdBeatValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrReq_o       (memWrReq_o),
    .memWrReady_i     (memWrReady_i)
  );

endmodule

`default_nettype wire

//--- verilog/dcacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl
  import dcachePkg::*;
#(
  parameter int IndexWidth = 6
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        cpuReqValid_i,
  input  cpuReq_t                                     cpuReq_i,
  output logic                                        cpuAck_o,
  output logic [XLEN-1:0]                             cpuRdata_o,
  output logic [IndexWidth-1:0]                       lookupIndex_o,
  output logic [AddrWidth-IndexWidth-OffsetWidth-1:0] lookupTag_o,
  input  logic                                        hit_i,
  input  logic                                        hitWay_i,
  input  logic                                        victimWay_i,
  input  logic                                        victimDirty_i,
  input  logic [AddrWidth-IndexWidth-OffsetWidth-1:0] victimTag_i,
  input  line_t [1:0]                                 readLines_i,
  output logic [1:0]                                  wayWrite_o,
  output logic                                        storeMerge_o,
  output cpuReq_t                                     storeReq_o,
  output logic                                        tagCommit_o,
  output logic                                        setDirty_o,
  output logic                                        fillStart_o,
  output logic                                        wbStart_o,
  output logic [AddrWidth-1:0]                        wbAddr_o,
  output line_t                                       wbLine_o,
  output logic [AddrWidth-1:0]                        fillAddr_o,
  input  logic                                        fillDone_i,
  input  logic                                        wbDone_i
);

  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    Fill,
    RefillWrite,
    Respond
  } state_t;

  state_t          state;
  state_t          nextState;
  cpuReq_t         reqQ;
  logic [XLEN-1:0] rdataQ;
  logic            ackQ;
  logic            lookupHit;
  logic            lookupMiss;

  assign lookupIndex_o = reqQ.addr[OffsetWidth +: IndexWidth];
  assign lookupTag_o   = reqQ.addr[AddrWidth-1 -: TagWidth];

  assign lookupHit  = (state == Lookup) && hit_i;
  assign lookupMiss = (state == Lookup) && !hit_i;

  always_comb begin
    nextState = state;
    case (state)
      Idle:        if (cpuReqValid_i) nextState = Lookup;
      Lookup: begin
        if (hit_i) begin
          nextState = Respond;
        end else if (victimDirty_i) begin
          nextState = WriteBack;
        end else begin
          nextState = Fill;
        end
      end
      WriteBack:   if (wbDone_i) nextState = Fill;
      Fill:        if (fillDone_i) nextState = RefillWrite;
      // replay the lookup once the new line is in place
      RefillWrite: nextState = Lookup;
      Respond:     if (ackQ && !cpuReqValid_i) nextState = Idle;
      default:     nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
      ackQ  <= 1'b0;
    end else begin
      state <= nextState;
      if (state == Respond) begin
        if (!ackQ) begin
          ackQ <= 1'b1;
        end else if (!cpuReqValid_i) begin
          ackQ <= 1'b0;
        end
      end
    end
  end

  // request and load data
  always_ff @(posedge clk) begin
    if (state == Idle && cpuReqValid_i) begin
      reqQ <= cpuReq_i;
    end
    if (lookupHit && !reqQ.isWrite) begin
      rdataQ <= readLines_i[hitWay_i][wordSel(reqQ.addr)*XLEN +: XLEN];
    end
  end

  assign cpuAck_o   = ackQ;
  assign cpuRdata_o = rdataQ;

  // store hit merges into the hit way, refill goes to the victim way
  assign storeMerge_o = lookupHit && reqQ.isWrite;
  assign setDirty_o   = storeMerge_o;
  assign storeReq_o   = reqQ;
  assign tagCommit_o  = (state == RefillWrite);

  always_comb begin
    wayWrite_o = 2'b00;
    if (storeMerge_o) begin
      wayWrite_o[hitWay_i] = 1'b1;
    end else if (tagCommit_o) begin
      wayWrite_o[victimWay_i] = 1'b1;
    end
  end

  // miss sequencing
  assign wbStart_o   = lookupMiss && victimDirty_i;
  assign fillStart_o = (lookupMiss && !victimDirty_i) || (state == WriteBack && wbDone_i);
  assign wbAddr_o    = {victimTag_i, lookupIndex_o, {OffsetWidth{1'b0}}};
  assign wbLine_o    = readLines_i[victimWay_i];
  assign fillAddr_o  = lineAlign(reqQ.addr);

endmodule

`default_nettype wire

//--- verilog/lineTransfer.sv
`timescale 1ns/1ps
`default_nettype none

module lineTransfer
  import dcachePkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fillStart_i,
  input  logic [AddrWidth-1:0] fillAddr_i,
  input  logic                 wbStart_i,
  input  logic [AddrWidth-1:0] wbAddr_i,
  input  line_t                wbLine_i,
  output logic                 fillDone_o,
  output logic                 wbDone_o,
  output line_t                fillLine_o,
  output logic                 memRdValid_o,
  output memRdReq_t            memRdReq_o,
  input  logic                 memRdReady_i,
  input  logic [XLEN-1:0]      memRdData_i,
  input  logic                 memRdBeatValid_i,
  input  logic                 memRdLast_i,
  output logic                 memWrValid_o,
  output memWrReq_t            memWrReq_o,
  input  logic                 memWrReady_i
);

  logic                    rdValidQ;
  logic                    wrValidQ;
  logic                    filling;
  logic [WordSelWidth-1:0] beatCnt;
  logic                    fillDoneQ;
  logic                    wbDoneQ;
  memRdReq_t               rdReqQ;
  memWrReq_t               wrReqQ;
  line_t                   lineBuf;

  // control flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdValidQ  <= 1'b0;
      wrValidQ  <= 1'b0;
      filling   <= 1'b0;
      beatCnt   <= '0;
      fillDoneQ <= 1'b0;
      wbDoneQ   <= 1'b0;
    end else begin
      fillDoneQ <= 1'b0;
      wbDoneQ   <= 1'b0;
      if (wbStart_i) begin
        wrValidQ <= 1'b1;
      end else if (wrValidQ && memWrReady_i) begin
        wrValidQ <= 1'b0;
        wbDoneQ  <= 1'b1;
      end
      if (fillStart_i) begin
        rdValidQ <= 1'b1;
        filling  <= 1'b1;
        beatCnt  <= '0;
      end else begin
        if (rdValidQ && memRdReady_i) begin
          rdValidQ <= 1'b0;
        end
        if (filling && memRdBeatValid_i) begin
          beatCnt <= beatCnt + 1'b1;
          if (memRdLast_i) begin
            filling   <= 1'b0;
            fillDoneQ <= 1'b1;
          end
        end
      end
    end
  end

  // request payloads and the refill buffer
  always_ff @(posedge clk) begin
    if (wbStart_i) begin
      wrReqQ.addr <= wbAddr_i;
      wrReqQ.data <= wbLine_i;
    end
    if (fillStart_i) begin
      rdReqQ.addr <= fillAddr_i;
    end
    if (filling && memRdBeatValid_i) begin
      lineBuf[beatCnt*XLEN +: XLEN] <= memRdData_i;
    end
  end

  assign memRdValid_o = rdValidQ;
  assign memRdReq_o   = rdReqQ;
  assign memWrValid_o = wrValidQ;
  assign memWrReq_o   = wrReqQ;
  assign fillDone_o   = fillDoneQ;
  assign wbDone_o     = wbDoneQ;
  assign fillLine_o   = lineBuf;

endmodule

`default_nettype wire

//--- verilog/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore
  import dcachePkg::*;
#(
  parameter int IndexWidth = 6
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [IndexWidth-1:0]                       lookupIndex_i,
  input  logic [AddrWidth-IndexWidth-OffsetWidth-1:0] lookupTag_i,
  input  logic                                        tagCommit_i,
  input  logic                                        setDirty_i,
  input  logic                                        hitWay_i,
  output logic                                        hit_o,
  output logic                                        hitWay_o,
  output logic                                        victimWay_o,
  output logic                                        victimDirty_o,
  output logic [AddrWidth-IndexWidth-OffsetWidth-1:0] victimTag_o
);

  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;
  localparam int Sets     = 2 ** IndexWidth;

  logic [TagWidth-1:0] tagArr [2][Sets];
  logic [Sets-1:0]     validQ [2];
  logic [Sets-1:0]     dirtyQ [2];
  logic                victimPtr;
  logic [1:0]          wayHit;

  // combinational compare on both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][lookupIndex_i] && (tagArr[w][lookupIndex_i] == lookupTag_i);
    end
  end

  assign hit_o         = |wayHit;
  assign hitWay_o      = wayHit[1];
  assign victimWay_o   = victimPtr;
  assign victimDirty_o = validQ[victimPtr][lookupIndex_i] && dirtyQ[victimPtr][lookupIndex_i];
  assign victimTag_o   = tagArr[victimPtr][lookupIndex_i];

  always_ff @(posedge clk) begin
    if (tagCommit_i) begin
      tagArr[victimPtr][lookupIndex_i] <= lookupTag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ[0] <= '0;
      validQ[1] <= '0;
      dirtyQ[0] <= '0;
      dirtyQ[1] <= '0;
      victimPtr <= 1'b0;
    end else if (tagCommit_i) begin
      validQ[victimPtr][lookupIndex_i] <= 1'b1;
      dirtyQ[victimPtr][lookupIndex_i] <= 1'b0;
      // alternate between ways on every refill
      victimPtr <= ~victimPtr;
    end else if (setDirty_i) begin
      dirtyQ[hitWay_i][lookupIndex_i] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore
  import dcachePkg::*;
#(
  parameter int IndexWidth = 6
) (
  input  logic                  clk,
  input  logic [1:0]            wayWrite_i,
  input  logic                  storeMerge_i,
  input  logic [IndexWidth-1:0] index_i,
  input  cpuReq_t               storeReq_i,
  input  line_t                 fillLine_i,
  output line_t [1:0]           readLines_o
);

  localparam int Sets = 2 ** IndexWidth;

  line_t           lines [2][Sets];
  logic [XLEN-1:0] wordMask;
  line_t           mergeMask;
  line_t           mergeData;

  // expand byte enables to bit enables
  always_comb begin
    for (int b = 0; b < MaskWidth; b++) begin
      wordMask[b*8 +: 8] = {8{storeReq_i.byteMask[b]}};
    end
  end

  // place the word at its slot in the line
  assign mergeMask = line_t'(wordMask) << (wordSel(storeReq_i.addr) * XLEN);
  assign mergeData = line_t'(storeReq_i.wdata) << (wordSel(storeReq_i.addr) * XLEN);

  assign readLines_o[0] = lines[0][index_i];
  assign readLines_o[1] = lines[1][index_i];

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWrite_i[w]) begin
        if (storeMerge_i) begin
          lines[w][index_i] <= (readLines_o[w] & ~mergeMask) | (mergeData & mergeMask);
        end else begin
          lines[w][index_i] <= fillLine_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // pipeline and bus geometry
  localparam int XLEN         = 64;
  localparam int AddrWidth    = 32;
  localparam int LineBytes    = 32;
  localparam int BeatsPerLine = 4;
  localparam int OffsetWidth  = $clog2(LineBytes);
  localparam int WordSelWidth = $clog2(BeatsPerLine);
  localparam int MaskWidth    = XLEN / 8;

  typedef logic [LineBytes*8-1:0] line_t;

  typedef struct packed {
    logic                 isWrite;
    logic [AddrWidth-1:0] addr;
    logic [XLEN-1:0]      wdata;
    logic [MaskWidth-1:0] byteMask;
  } cpuReq_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } memRdReq_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    line_t                data;
  } memWrReq_t;

  // clear the byte offset to get the line address
  function automatic logic [AddrWidth-1:0] lineAlign(input logic [AddrWidth-1:0] addr);
    return {addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  endfunction

  // 64-bit word position inside the line
  function automatic logic [WordSelWidth-1:0] wordSel(input logic [AddrWidth-1:0] addr);
    return addr[OffsetWidth-1 -: WordSelWidth];
  endfunction

endpackage

`default_nettype wire
